// File: sim.f
+incdir+source
source/emu_io_pkg.sv
source/emu_dl_pkg.sv
source/clk_en_gen.sv
source/rom_loader.sv
source/hsync_delay.sv
source/emu_core_top.sv
dv/tb_emu_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_emu_core -o tb_emu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_emu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi
exit 0

// File: dv/tb_emu_core.sv
////////////////////////////////////////////////////////////
// table driven host bytes and an sdram ack with random latency
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "emu_cfg.svh"

module tb_emu_core;

    localparam int NUM_STIM = 14;
    localparam int WAIT_LIMIT = 64;
    localparam logic [15:0] LFSR_SEED = 16'(70594);
    localparam logic [15:0] IDX_IDLE = 16'hFFFF;
    localparam logic [1:0] KIND_DIP = 2'd0;
    localparam logic [1:0] KIND_BRAM = 2'd1;
    localparam logic [1:0] KIND_SDRAM = 2'd2;

    // one host byte and the block ram select it decodes to
    typedef struct packed {
        logic [1:0]  kind;
        logic [15:0] index;
        logic [26:0] addr;
        logic [7:0]  data;
        logic [4:0]  cs_n;
    } stim_t;

    logic i_EMU_MCLK;
    logic i_EMU_INITRST;
    logic [15:0] i_joystick0;
    logic [15:0] i_joystick1;
    emu_dl_pkg::host_byte_t i_host;
    logic i_sdram_ack;
    logic i_sdram_init;
    logic i_pxcen;
    logic i_hsync_n;
    logic i_hblank_n;
    logic o_clk12m_pcen_n;
    logic o_clk5m_pcen_n;
    logic o_clk5m_ncen_n;
    emu_io_pkg::btn_byte_t o_sys_btn;
    emu_io_pkg::btn_byte_t o_p1_btn;
    emu_io_pkg::btn_byte_t o_p2_btn;
    emu_dl_pkg::sdram_prog_t o_sdram_prog;
    emu_dl_pkg::bram_prog_t o_bram_prog;
    emu_io_pkg::dipsw_t o_dipsw;
    logic o_ioctl_wait;
    logic o_rom_done;
    logic o_hsync_n;
    logic o_hblank_n;

    stim_t stim_tbl [NUM_STIM];
    int mismatches;
    int timeouts;
    logic [15:0] rnd_state;
    logic [15:0] ack_state;

    emu_core_top emu_core_top_i (.*);

    initial begin
        i_EMU_MCLK = 1'b0;
        forever #20 i_EMU_MCLK = ~i_EMU_MCLK;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] st, input int n, output logic [15:0] v);
        int b;
        v = '0;
        for (b = 0; b < n; b++) begin
            v = {v[14:0], st[15]};
            st = lfsr_step(st);
        end
    endtask

    task automatic tick();
        @(posedge i_EMU_MCLK);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[FAIL] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t ns waiting for %s", $time, what);
        timeouts++;
    endtask

    // active low cabinet bytes written out bit by bit
    function automatic logic [23:0] expected_buttons(input logic [15:0] j0,
                                                     input logic [15:0] j1);
        logic [7:0] s;
        logic [7:0] p1;
        logic [7:0] p2;
        s[0] = ~j0[9];
        s[1] = ~j1[9];
        s[3:2] = 2'b11;
        s[4] = ~j0[6];
        s[5] = ~j0[7];
        s[6] = ~j0[8];
        s[7] = ~j1[8];
        p1[3:0] = ~j0[3:0];
        p1[4] = ~j0[5];
        p1[5] = ~j0[4];
        p1[7:6] = 2'b11;
        p2[5:0] = ~j1[5:0];
        p2[7:6] = 2'b11;
        return {s, p1, p2};
    endfunction

    // host side of the loader holds off while wait is high
    task automatic send_byte(input logic [15:0] idx, input logic [26:0] addr,
                             input logic [7:0] data);
        int n;
        n = 0;
        while (o_ioctl_wait && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (o_ioctl_wait) report_timeout("o_ioctl_wait to fall");
        i_host = '{index: idx, addr: addr, data: data, wr: 1'b1};
        tick();
        i_host.wr = 1'b0;
    endtask

    task automatic check_sdram_word(input logic [26:0] addr, input logic [15:0] word);
        emu_dl_pkg::sdram_prog_t exp_prog;
        int n;
        logic acked;
        exp_prog = '{en: 1'b1, wr: 1'b1, ba: {1'b0, addr[17]}, addr: {6'd0, addr[16:1]},
                     data: word};
        if (o_sdram_prog !== exp_prog) report_mismatch("o_sdram_prog", 64'(o_sdram_prog),
                                                       64'(exp_prog));
        n = 0;
        while (o_sdram_prog.wr && n < WAIT_LIMIT) begin
            if (o_ioctl_wait !== 1'b1) report_mismatch("o_ioctl_wait", 64'(o_ioctl_wait), 64'd1);
            // ack settles 2 ns after the edge
            #1;
            acked = i_sdram_ack;
            tick();
            n++;
            if (acked) begin
                // wr drops on the edge that saw ack
                if (o_sdram_prog.wr !== 1'b0) begin
                    report_mismatch("o_sdram_prog.wr", 64'(o_sdram_prog.wr), 64'd0);
                end
            end else if (o_sdram_prog !== exp_prog) begin
                report_mismatch("o_sdram_prog held", 64'(o_sdram_prog), 64'(exp_prog));
            end
        end
        if (o_sdram_prog.wr) report_timeout("sdram ack to clear wr");
        else if (o_ioctl_wait !== 1'b0) report_mismatch("o_ioctl_wait", 64'(o_ioctl_wait), 64'd0);
    endtask

    ////////////////////////////////////////////////////////////
    // sdram ack model answers 0 to 7 cycles after wr is seen
    ////////////////////////////////////////////////////////////
    initial begin : ack_model
        logic [15:0] dly;
        int left;
        logic armed;
        i_sdram_ack = 1'b0;
        ack_state = LFSR_SEED;
        armed = 1'b0;
        left = 0;
        forever begin
            tick();
            if (i_sdram_ack) begin
                i_sdram_ack = 1'b0;
            end else if (o_sdram_prog.wr) begin
                if (!armed) begin
                    draw_bits(ack_state, 3, dly);
                    left = int'(dly);
                    armed = 1'b1;
                end
                if (left == 0) begin
                    i_sdram_ack = 1'b1;
                    armed = 1'b0;
                end else begin
                    left--;
                end
            end
        end
    end

    initial begin
        #100000;
        $display("simulation did not finish within the time limit");
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin : main_seq
        int i;
        int n;
        stim_t s;
        logic [15:0] j0;
        logic [15:0] j1;
        logic [15:0] v;
        logic [23:0] exp_btn;
        logic [7:0] hi_byte;
        logic [1:0] sent [0:31];
        logic [1:0] exp_sync;
        emu_io_pkg::dipsw_t exp_dip;
        i_EMU_INITRST = 1'b1;
        i_joystick0 = '0;
        i_joystick1 = '0;
        i_host = '{index: IDX_IDLE, addr: '0, data: '0, wr: 1'b0};
        i_sdram_init = 1'b0;
        i_pxcen = 1'b0;
        i_hsync_n = 1'b1;
        i_hblank_n = 1'b1;
        mismatches = 0;
        timeouts = 0;
        rnd_state = LFSR_SEED;
        hi_byte = '0;
        exp_dip = {`EMU_DIPSW1_DEFAULT, `EMU_DIPSW2_DEFAULT};
        stim_tbl[0]  = '{KIND_DIP, `EMU_DL_IDX_DIPSW, 27'h0000000, 8'h5A, 5'h1F};
        stim_tbl[1]  = '{KIND_DIP, `EMU_DL_IDX_DIPSW, 27'h0000001, 8'hC3, 5'h1F};
        stim_tbl[2]  = '{KIND_DIP, `EMU_DL_IDX_DIPSW, 27'h0000002, 8'h99, 5'h1F};
        stim_tbl[3]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0040123, 8'h01, 5'b10111};
        stim_tbl[4]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0060456, 8'h02, 5'b11011};
        stim_tbl[5]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0068789, 8'h03, 5'b01111};
        stim_tbl[6]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0070155, 8'h04, 5'b11101};
        stim_tbl[7]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0070433, 8'h05, 5'b11110};
        stim_tbl[8]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0070611, 8'h06, 5'b11111};
        stim_tbl[9]  = '{KIND_BRAM, `EMU_DL_IDX_ROM, 27'h0078022, 8'h07, 5'b11111};
        stim_tbl[10] = '{KIND_SDRAM, `EMU_DL_IDX_ROM, 27'h0000246, 8'h12, 5'h1F};
        stim_tbl[11] = '{KIND_SDRAM, `EMU_DL_IDX_ROM, 27'h0000247, 8'h34, 5'h1F};
        stim_tbl[12] = '{KIND_SDRAM, `EMU_DL_IDX_ROM, 27'h002A00A, 8'hAB, 5'h1F};
        stim_tbl[13] = '{KIND_SDRAM, `EMU_DL_IDX_ROM, 27'h002A00B, 8'hCD, 5'h1F};
        repeat (10) tick();

        // idle values while reset is held
        if (o_sdram_prog.wr !== 1'b0) report_mismatch("o_sdram_prog.wr", 64'(o_sdram_prog.wr), 0);
        if (o_sdram_prog.en !== 1'b0) report_mismatch("o_sdram_prog.en", 64'(o_sdram_prog.en), 0);
        if (o_bram_prog.wr_n !== 1'b1) begin
            report_mismatch("o_bram_prog.wr_n", 64'(o_bram_prog.wr_n), 1);
        end
        if (o_bram_prog.cs_n !== 5'h1F) begin
            report_mismatch("o_bram_prog.cs_n", 64'(o_bram_prog.cs_n), 31);
        end
        if (o_rom_done !== 1'b0) report_mismatch("o_rom_done", 64'(o_rom_done), 0);
        if ({o_hsync_n, o_hblank_n} !== 2'b11) report_mismatch("o_hsync_n/o_hblank_n",
                                                               64'({o_hsync_n, o_hblank_n}), 3);
        if (o_dipsw !== exp_dip) report_mismatch("o_dipsw", 64'(o_dipsw), 64'(exp_dip));
        i_EMU_INITRST = 1'b0;

        // edge n counts from the first edge out of reset
        for (n = 1; n <= 60; n++) begin
            tick();
            if (o_clk12m_pcen_n !== (n % 5 != 4)) begin
                report_mismatch("o_clk12m_pcen_n", 64'(o_clk12m_pcen_n), 64'(n % 5 != 4));
            end
            if (o_clk5m_pcen_n !== (n % 12 != 5)) begin
                report_mismatch("o_clk5m_pcen_n", 64'(o_clk5m_pcen_n), 64'(n % 12 != 5));
            end
            if (o_clk5m_ncen_n !== (n % 12 != 11)) begin
                report_mismatch("o_clk5m_ncen_n", 64'(o_clk5m_ncen_n), 64'(n % 12 != 11));
            end
        end

        for (i = 0; i < 32; i++) begin
            draw_bits(rnd_state, 16, j0);
            draw_bits(rnd_state, 16, j1);
            i_joystick0 = j0;
            i_joystick1 = j1;
            #1;
            exp_btn = expected_buttons(j0, j1);
            if ({o_sys_btn, o_p1_btn, o_p2_btn} !== exp_btn) begin
                report_mismatch("o_sys_btn/o_p1_btn/o_p2_btn",
                                64'({o_sys_btn, o_p1_btn, o_p2_btn}), 64'(exp_btn));
            end
            tick();
        end

        i_sdram_init = 1'b1;
        #1;
        if (o_ioctl_wait !== 1'b1) report_mismatch("o_ioctl_wait", 64'(o_ioctl_wait), 64'd1);
        tick();
        i_sdram_init = 1'b0;
        #1;
        if (o_ioctl_wait !== 1'b0) report_mismatch("o_ioctl_wait", 64'(o_ioctl_wait), 64'd0);
        tick();

        for (i = 0; i < NUM_STIM; i++) begin
            s = stim_tbl[i];
            send_byte(s.index, s.addr, s.data);
            case (s.kind)
                KIND_DIP: begin
                    // only addresses 0 and 1 hit a bank
                    if (s.addr == 27'd0) exp_dip.sw1 = s.data;
                    if (s.addr == 27'd1) exp_dip.sw2 = s.data;
                    if (o_dipsw !== exp_dip) report_mismatch("o_dipsw", 64'(o_dipsw), 64'(exp_dip));
                end
                KIND_BRAM: begin
                    if (o_bram_prog !== {s.addr[16:0], s.data, 1'b0, s.cs_n}) begin
                        report_mismatch("o_bram_prog", 64'(o_bram_prog),
                                        64'({s.addr[16:0], s.data, 1'b0, s.cs_n}));
                    end
                    tick();
                    if (o_bram_prog.wr_n !== 1'b1) begin
                        report_mismatch("o_bram_prog.wr_n", 64'(o_bram_prog.wr_n), 64'd1);
                    end
                end
                default: begin
                    if (!s.addr[0]) begin
                        hi_byte = s.data;
                    end else begin
                        check_sdram_word(s.addr, {hi_byte, s.data});
                    end
                end
            endcase
        end

        // leaving the sdram region closes the last of the three
        i_host.addr = 27'h0040000;
        tick();
        i_host.index = IDX_IDLE;
        n = 0;
        while (!o_rom_done && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!o_rom_done) report_timeout("o_rom_done");
        tick();
        send_byte(`EMU_DL_IDX_DIPSW, 27'h0000000, 8'h11);
        if (o_dipsw !== exp_dip) report_mismatch("o_dipsw", 64'(o_dipsw), 64'(exp_dip));
        send_byte(`EMU_DL_IDX_ROM, 27'h0040123, 8'h77);
        if (o_bram_prog.wr_n !== 1'b1) begin
            report_mismatch("o_bram_prog.wr_n", 64'(o_bram_prog.wr_n), 1);
        end
        if (o_bram_prog.cs_n !== 5'h1F) begin
            report_mismatch("o_bram_prog.cs_n", 64'(o_bram_prog.cs_n), 31);
        end
        send_byte(`EMU_DL_IDX_ROM, 27'h0000001, 8'h55);
        if (o_sdram_prog.wr !== 1'b0) report_mismatch("o_sdram_prog.wr", 64'(o_sdram_prog.wr), 0);

        // pixel enable every third cycle and the output lags 5 enables
        n = 0;
        for (i = 0; i < 96; i++) begin
            i_pxcen = (i % 3 == 0);
            if (i_pxcen) begin
                draw_bits(rnd_state, 2, v);
                sent[n] = v[1:0];
                {i_hsync_n, i_hblank_n} = v[1:0];
            end
            tick();
            if (i_pxcen) n++;
            exp_sync = (n >= `EMU_SYNC_DLY) ? sent[n - `EMU_SYNC_DLY] : 2'b11;
            if ({o_hsync_n, o_hblank_n} !== exp_sync) begin
                report_mismatch("o_hsync_n/o_hblank_n", 64'({o_hsync_n, o_hblank_n}),
                                64'(exp_sync));
            end
        end
        i_pxcen = 1'b0;

        $display("mismatches: %0d  timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: source/emu_core_top.sv
////////////////////////////////////////////////////////////
// housekeeping around the game board, board itself external
// sdram controller answers on i_sdram_ack and i_sdram_init
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "emu_cfg.svh"

module emu_core_top (
    input  logic                    i_EMU_MCLK,
    input  logic                    i_EMU_INITRST,

    input  logic [`EMU_JOY_W-1:0]   i_joystick0,
    input  logic [`EMU_JOY_W-1:0]   i_joystick1,

    input  emu_dl_pkg::host_byte_t  i_host,
    input  logic                    i_sdram_ack,
    input  logic                    i_sdram_init,

    input  logic                    i_pxcen,
    input  logic                    i_hsync_n,
    input  logic                    i_hblank_n,

    output logic                    o_clk12m_pcen_n,
    output logic                    o_clk5m_pcen_n,
    output logic                    o_clk5m_ncen_n,

    output emu_io_pkg::btn_byte_t   o_sys_btn,
    output emu_io_pkg::btn_byte_t   o_p1_btn,
    output emu_io_pkg::btn_byte_t   o_p2_btn,

    output emu_dl_pkg::sdram_prog_t o_sdram_prog,
    output emu_dl_pkg::bram_prog_t  o_bram_prog,
    output emu_io_pkg::dipsw_t      o_dipsw,
    output logic                    o_ioctl_wait,
    output logic                    o_rom_done,

    output logic                    o_hsync_n,
    output logic                    o_hblank_n
);

    emu_io_pkg::hsync_t sync_raw;
    emu_io_pkg::hsync_t sync_dly;

    ////////////////////////////////////////////////////////////
    // clock enables
    ////////////////////////////////////////////////////////////
    clk_en_gen clk_en_gen_i (
        .i_EMU_MCLK      (i_EMU_MCLK),
        .i_EMU_INITRST   (i_EMU_INITRST),
        .o_clk12m_pcen_n (o_clk12m_pcen_n),
        .o_clk5m_pcen_n  (o_clk5m_pcen_n),
        .o_clk5m_ncen_n  (o_clk5m_ncen_n)
    );

    // buttons go straight through, no registering
    always_comb begin
        emu_io_pkg::map_buttons(i_joystick0, i_joystick1, o_sys_btn, o_p1_btn, o_p2_btn);
    end

    ////////////////////////////////////////////////////////////
    // rom download
    ////////////////////////////////////////////////////////////
    rom_loader rom_loader_i (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .i_host        (i_host),
        .i_sdram_ack   (i_sdram_ack),
        .i_sdram_init  (i_sdram_init),
        .o_sdram_prog  (o_sdram_prog),
        .o_bram_prog   (o_bram_prog),
        .o_dipsw       (o_dipsw),
        .o_ioctl_wait  (o_ioctl_wait),
        .o_rom_done    (o_rom_done)
    );

    ////////////////////////////////////////////////////////////
    // sync delay
    ////////////////////////////////////////////////////////////
    assign sync_raw.hsync_n  = i_hsync_n;
    assign sync_raw.hblank_n = i_hblank_n;

    hsync_delay hsync_delay_i (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_EMU_INITRST (i_EMU_INITRST),
        .i_pxcen       (i_pxcen),
        .i_sync        (sync_raw),
        .o_sync        (sync_dly)
    );

    assign o_hsync_n  = sync_dly.hsync_n;
    assign o_hblank_n = sync_dly.hblank_n;

endmodule

// File: source/hsync_delay.sv
////////////////////////////////////////////////////////////
// delay counts pixel enables, not master clocks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "emu_cfg.svh"

module hsync_delay (
    input  logic               i_EMU_MCLK,
    input  logic               i_EMU_INITRST,
    input  logic               i_pxcen,
    input  emu_io_pkg::hsync_t i_sync,
    output emu_io_pkg::hsync_t o_sync
);

    // stage 0 takes the raw pair
    emu_io_pkg::hsync_t [`EMU_SYNC_DLY-1:0] dly_line;

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            // both signals idle high
            dly_line <= '1;
        end else if (i_pxcen) begin
            dly_line <= {dly_line[`EMU_SYNC_DLY-2:0], i_sync};
        end
    end

    assign o_sync = dly_line[`EMU_SYNC_DLY-1];

endmodule

// File: source/rom_loader.sv
////////////////////////////////////////////////////////////
// host must hold its byte while o_ioctl_wait is high
// dip settings survive the end of the download
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "emu_cfg.svh"

module rom_loader (
    input  logic                    i_EMU_MCLK,
    input  logic                    i_EMU_INITRST,
    input  emu_dl_pkg::host_byte_t  i_host,
    input  logic                    i_sdram_ack,
    input  logic                    i_sdram_init,
    output emu_dl_pkg::sdram_prog_t o_sdram_prog,
    output emu_dl_pkg::bram_prog_t  o_bram_prog,
    output emu_io_pkg::dipsw_t      o_dipsw,
    output logic                    o_ioctl_wait,
    output logic                    o_rom_done
);

    emu_dl_pkg::sdram_prog_t              sdram_q;
    emu_dl_pkg::bram_prog_t               bram_q;
    emu_io_pkg::dipsw_t                   dipsw_q;
    logic                                 bram_en;
    logic                                 dipsw_en;
    logic                                 rom_done;
    logic                                 host_wr;
    logic                                 is_rom;
    logic                                 is_dip;
    logic                                 dip_addr_ok;
    logic [emu_dl_pkg::BRAM_CS_N-1:0]     bram_cs_dec;
    logic [2:0]                           en_now;
    logic [2:0]                           en_q;
    logic [2:0]                           done_flags;

    assign is_rom      = (i_host.index == `EMU_DL_IDX_ROM);
    assign is_dip      = (i_host.index == `EMU_DL_IDX_DIPSW);
    assign dip_addr_ok = (i_host.addr[24:1] == '0);
    // no new bytes taken while an sdram word is pending
    assign host_wr     = i_host.wr & ~sdram_q.wr;

    ////////////////////////////////////////////////////////////
    // block ram chip-select decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        bram_cs_dec = '1;
        if (!i_host.addr[17]) begin
            bram_cs_dec[emu_dl_pkg::BRAM_CS_BG] = 1'b0;
        end else begin
            case (i_host.addr[16:15])
                2'b00: bram_cs_dec[emu_dl_pkg::BRAM_CS_FG] = 1'b0;
                2'b01: bram_cs_dec[emu_dl_pkg::BRAM_CS_SOUND] = 1'b0;
                2'b10: begin
                    // sequencer prom then grayscale lut share this window
                    if (!i_host.addr[10]) begin
                        bram_cs_dec[emu_dl_pkg::BRAM_CS_SEQ] = 1'b0;
                    end else if (i_host.addr[10:9] == 2'b10) begin
                        bram_cs_dec[emu_dl_pkg::BRAM_CS_GRAY] = 1'b0;
                    end
                end
                default: bram_cs_dec = '1;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // download router
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST || rom_done) begin
            sdram_q.en   <= 1'b0;
            sdram_q.wr   <= 1'b0;
            sdram_q.ba   <= 2'd0;
            sdram_q.addr <= '1;
            sdram_q.data <= '1;
            bram_q.addr  <= '1;
            bram_q.data  <= '1;
            bram_q.wr_n  <= 1'b1;
            bram_q.cs_n  <= '1;
            bram_en      <= 1'b0;
            dipsw_en     <= 1'b0;
        end else begin
            bram_q.wr_n <= 1'b1;
            if (sdram_q.wr && i_sdram_ack) begin
                sdram_q.wr <= 1'b0;
            end

            if (is_rom) begin
                sdram_q.en <= ~i_host.addr[`EMU_ADDR_BRAM_SEL];
                bram_en    <= i_host.addr[`EMU_ADDR_BRAM_SEL];
                dipsw_en   <= 1'b0;
                if (host_wr && i_host.addr[`EMU_ADDR_BRAM_SEL]) begin
                    bram_q.addr <= i_host.addr[`EMU_BRAM_AW-1:0];
                    bram_q.data <= i_host.data;
                    bram_q.wr_n <= 1'b0;
                    bram_q.cs_n <= bram_cs_dec;
                end else if (host_wr && !i_host.addr[0]) begin
                    // even byte is the upper half of the word
                    sdram_q.data[15:8] <= i_host.data;
                end else if (host_wr) begin
                    sdram_q.data[7:0] <= i_host.data;
                    sdram_q.wr        <= 1'b1;
                    sdram_q.addr      <= `EMU_SDRAM_AW'(i_host.addr[16:1]);
                    sdram_q.ba        <= {1'b0, i_host.addr[`EMU_ADDR_BANK_SEL]};
                end
            end else if (is_dip) begin
                sdram_q.en <= 1'b0;
                bram_en    <= 1'b0;
                dipsw_en   <= dip_addr_ok;
            end
        end
    end

    // dip banks, loaded from index 254
    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            dipsw_q.sw1 <= `EMU_DIPSW1_DEFAULT;
            dipsw_q.sw2 <= `EMU_DIPSW2_DEFAULT;
        end else if (!rom_done && is_dip && dip_addr_ok && host_wr) begin
            if (!i_host.addr[0]) begin
                dipsw_q.sw1 <= i_host.data;
            end else begin
                dipsw_q.sw2 <= i_host.data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // download complete
    ////////////////////////////////////////////////////////////
    assign en_now = {sdram_q.en, bram_en, dipsw_en};

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            en_q       <= 3'b000;
            done_flags <= 3'b000;
            rom_done   <= 1'b0;
        end else begin
            en_q       <= en_now;
            // a region counts as loaded once the host leaves it
            done_flags <= done_flags | (en_q & ~en_now);
            rom_done   <= &done_flags;
        end
    end

    assign o_sdram_prog = sdram_q;
    assign o_bram_prog  = bram_q;
    assign o_dipsw      = dipsw_q;
    assign o_ioctl_wait = i_sdram_init | sdram_q.wr;
    assign o_rom_done   = rom_done;

endmodule

// File: source/clk_en_gen.sv
////////////////////////////////////////////////////////////
// enables are active low, each low for one master clock
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "emu_cfg.svh"

module clk_en_gen (
    input  logic i_EMU_MCLK,
    input  logic i_EMU_INITRST,
    output logic o_clk12m_pcen_n,
    output logic o_clk5m_pcen_n,
    output logic o_clk5m_ncen_n
);

    // divide by 5 for the 12 MHz enable
    logic [4:0]  div5_ring;
    // divide by 12 for the 5 MHz pair
    logic [11:0] div12_ring;

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            div5_ring <= `EMU_DIV5_INIT;
        end else begin
            div5_ring <= {div5_ring[3:0], div5_ring[4]};
        end
    end

    always_ff @(posedge i_EMU_MCLK) begin
        if (i_EMU_INITRST) begin
            div12_ring <= `EMU_DIV12_INIT;
        end else begin
            div12_ring <= {div12_ring[10:0], div12_ring[11]};
        end
    end

    assign o_clk12m_pcen_n = div5_ring[4];
    // taps half a period apart give the positive and negative phases
    assign o_clk5m_pcen_n  = div12_ring[11];
    assign o_clk5m_ncen_n  = div12_ring[5];

endmodule

// File: source/emu_dl_pkg.sv
////////////////////////////////////////////////////////////
// download side types for the host loader and rom targets
////////////////////////////////////////////////////////////
`include "emu_cfg.svh"

package emu_dl_pkg;

    // number of block ram chip selects
    localparam int BRAM_CS_N = 5;

    // chip-select positions inside cs_n
    localparam int BRAM_CS_SOUND = 4;
    localparam int BRAM_CS_BG    = 3;
    localparam int BRAM_CS_FG    = 2;
    localparam int BRAM_CS_SEQ   = 1;
    localparam int BRAM_CS_GRAY  = 0;

    // one byte from the host loader
    typedef struct packed {
        logic [`EMU_HOST_IW-1:0] index;
        logic [`EMU_HOST_AW-1:0] addr;
        logic [7:0]              data;
        logic                    wr;
    } host_byte_t;

    // sdram programming port, wr held until ack
    typedef struct packed {
        logic                     en;
        logic                     wr;
        logic [1:0]               ba;
        logic [`EMU_SDRAM_AW-1:0] addr;
        logic [`EMU_SDRAM_DW-1:0] data;
    } sdram_prog_t;

    // block ram programming port, one cycle strobes
    typedef struct packed {
        logic [`EMU_BRAM_AW-1:0] addr;
        logic [7:0]              data;
        logic                    wr_n;
        logic [BRAM_CS_N-1:0]    cs_n;
    } bram_prog_t;

endpackage

// File: source/emu_io_pkg.sv
////////////////////////////////////////////////////////////
// cabinet side types, all button bytes are active low
////////////////////////////////////////////////////////////
`include "emu_cfg.svh"

package emu_io_pkg;

    // one byte of cabinet buttons, 0 = pressed
    typedef logic [7:0] btn_byte_t;

    // dip banks as seen by the board
    typedef struct packed {
        logic [7:0] sw1;
        logic [7:0] sw2;
    } dipsw_t;

    // raw or delayed horizontal timing pair
    typedef struct packed {
        logic hsync_n;
        logic hblank_n;
    } hsync_t;

    ////////////////////////////////////////////////////////////
    // joystick to cabinet mapping
    // host joystick bits: 0 right, 1 left, 2 down, 3 up,
    // 4 attack, 5 jump, 6 test, 7 service, 8 coin, 9 start
    ////////////////////////////////////////////////////////////
    function automatic void map_buttons(
        input  logic [`EMU_JOY_W-1:0] j0,
        input  logic [`EMU_JOY_W-1:0] j1,
        output btn_byte_t             sys,
        output btn_byte_t             p1,
        output btn_byte_t             p2
    );
        // coin2, coin1, service, test, unused pair, start2, start1
        sys = {~j1[8], ~j0[8], ~j0[7], ~j0[6], 2'b11, ~j1[9], ~j0[9]};

        // player 1 has attack and jump swapped on the board
        p1 = {2'b11, ~j0[4], ~j0[5], ~j0[3:0]};

        // player 2, cocktail cabinet only
        p2 = {2'b11, ~j1[5:0]};
    endfunction

endpackage

// File: source/emu_cfg.svh
////////////////////////////////////////////////////////////
// widths and constants for the emulator housekeeping logic
// ring patterns assume the reference 60 MHz master clock
////////////////////////////////////////////////////////////
`ifndef EMU_CFG_SVH
`define EMU_CFG_SVH

// bus widths
`define EMU_JOY_W           16
`define EMU_HOST_IW         16
`define EMU_HOST_AW         27
`define EMU_SDRAM_AW        22
`define EMU_SDRAM_DW        16
`define EMU_BRAM_AW         17

// divider rings, one zero rotating
`define EMU_DIV5_INIT       5'b11110
`define EMU_DIV12_INIT      12'b111110_111111

// host download indices
`define EMU_DL_IDX_ROM      16'd0
`define EMU_DL_IDX_DIPSW    16'd254

// rom image address bits
`define EMU_ADDR_BRAM_SEL   18
`define EMU_ADDR_BANK_SEL   17

// dip switch power-on values
`define EMU_DIPSW1_DEFAULT  8'hEF
`define EMU_DIPSW2_DEFAULT  8'hFF

// sync delay in pixel enables
`define EMU_SYNC_DLY        5

`endif
